// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// program counter after reset.
`define RESET_PC 32'h0000_0000

// one fetch packet holds two instruction words.
`define FETCH_BYTES 8

// integer and float register index width.
`define REG_AW 5

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
  localparam logic [6:0] OPC_FMADD    = 7'b1000011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // same order as funct3.
  typedef enum logic [2:0] {
    MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU,
    MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU
  } mdu_op_t;

  // loads are {0, funct3}, stores are {1, funct3}.
  typedef enum logic [3:0] {
    LSU_LB  = 4'd0,
    LSU_LH  = 4'd1,
    LSU_LW  = 4'd2,
    LSU_LBU = 4'd4,
    LSU_LHU = 4'd5,
    LSU_SB  = 4'd8,
    LSU_SH  = 4'd9,
    LSU_SW  = 4'd10,
    LSU_FW  = 4'd15
  } lsu_op_t;

  typedef enum logic [2:0] {
    FPU_ADD, FPU_SUB, FPU_MUL, FPU_DIV, FPU_MADD
  } fpu_op_t;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic fwren;
    logic frden1;
    logic frden2;
    logic frden3;
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fload;
    logic fstore;
    logic fpu;
    logic mdu;
    logic csreg;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic valid;
    logic exception;
  } op_flags_t;

  typedef struct packed {
    logic [31:0] imm;
    op_flags_t   op;
    alu_op_t     alu_op;
    mdu_op_t     mdu_op;
    lsu_op_t     lsu_op;
    fpu_op_t     fpu_op;
    logic [2:0]  rm;
    logic [1:0]  fmt;
  } dec_result_t;

endpackage

// ==== hw/pipe_pkg.sv ====
`include "rv_consts.svh"

package pipe_pkg;

  import isa_pkg::*;

  typedef struct packed {
    logic                        ready;
    logic [`FETCH_BYTES*8-1:0]   rdata;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]         pc;
    logic [31:0]         npc;
    logic [31:0]         instr;
    logic [`REG_AW-1:0]  waddr;
    logic [`REG_AW-1:0]  raddr1;
    logic [`REG_AW-1:0]  raddr2;
    logic [`REG_AW-1:0]  raddr3;
    logic [11:0]         caddr;
    dec_result_t         dec;
  } slot_t;

  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
    logic  pair_ok;
  } issue_pkt_t;

endpackage

// ==== hw/int_decoder.sv ====
`timescale 1ns/1ps

module int_decoder
  import isa_pkg::*;
(
  input  logic [31:0] instr,
  output dec_result_t result
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        legal;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic alu_op_t alu_sel(logic [2:0] f3, logic alt);
    alu_op_t sel;
    case (f3)
      3'b000: sel = alt ? ALU_SUB : ALU_ADD;
      3'b001: sel = ALU_SLL;
      3'b010: sel = ALU_SLT;
      3'b011: sel = ALU_SLTU;
      3'b100: sel = ALU_XOR;
      3'b101: sel = alt ? ALU_SRA : ALU_SRL;
      3'b110: sel = ALU_OR;
      default: sel = ALU_AND;
    endcase
    return sel;
  endfunction

  always_comb begin
    result = '0;
    legal = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        result.imm = imm_u;
        result.op.wren = 1'b1;
        result.op.lui = (opcode == OPC_LUI);
        result.op.auipc = (opcode == OPC_AUIPC);
        legal = 1'b1;
      end
      OPC_JAL: begin
        result.imm = imm_j;
        result.op.wren = 1'b1;
        result.op.jal = 1'b1;
        legal = 1'b1;
      end
      OPC_JALR: begin
        result.imm = imm_i;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.jalr = 1'b1;
        legal = (funct3 == 3'b000);
      end
      OPC_BRANCH: begin
        result.imm = imm_b;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.branch = 1'b1;
        legal = (funct3[2:1] != 2'b01); // funct3 2 and 3 unused.
      end
      OPC_LOAD: begin
        result.imm = imm_i;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.load = 1'b1;
        result.lsu_op = lsu_op_t'({1'b0, funct3});
        legal = (funct3 != 3'b011) && (funct3 < 3'b110);
      end
      OPC_STORE: begin
        result.imm = imm_s;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.op.store = 1'b1;
        result.lsu_op = lsu_op_t'({1'b1, funct3});
        legal = (funct3 < 3'b011);
      end
      OPC_OP_IMM: begin
        result.imm = imm_i;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.alu = 1'b1;
        result.alu_op = alu_sel(funct3, (funct3 == 3'b101) & instr[30]);
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          legal = 1'b1;
        end
      end
      OPC_OP: begin
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        if (funct7 == 7'b0000001) begin
          result.op.mdu = 1'b1;
          result.mdu_op = mdu_op_t'(funct3);
          legal = 1'b1;
        end else begin
          result.op.alu = 1'b1;
          result.alu_op = alu_sel(funct3, instr[30]);
          legal = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        end
      end
      OPC_MISC_MEM: begin
        result.op.fence = 1'b1;
        legal = (funct3 == 3'b000);
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          result.op.ecall = (instr == 32'h0000_0073);
          result.op.ebreak = (instr == 32'h0010_0073);
          result.op.mret = (instr == 32'h3020_0073);
          result.op.wfi = (instr == 32'h1050_0073);
          legal = result.op.ecall | result.op.ebreak | result.op.mret | result.op.wfi;
        end else begin
          result.imm = {27'd0, instr[19:15]}; // zimm for the immediate forms.
          result.op.wren = 1'b1;
          result.op.rden1 = ~funct3[2];
          result.op.csreg = 1'b1;
          legal = (funct3 != 3'b100);
        end
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    if (legal) begin
      result.op.valid = 1'b1;
    end else begin
      result = '0;
    end
  end

endmodule

// ==== hw/fp_decoder.sv ====
`timescale 1ns/1ps

module fp_decoder
  import isa_pkg::*;
(
  input  logic [31:0] instr,
  output dec_result_t result
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       rm_ok;
  logic       legal;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rm_ok = (funct3 != 3'b101) && (funct3 != 3'b110); // 5 and 6 reserved.

  always_comb begin
    result = '0;
    legal = 1'b0;
    case (opcode)
      OPC_LOAD_FP: begin
        result.imm = {{20{instr[31]}}, instr[31:20]};
        result.op.rden1 = 1'b1;
        result.op.fwren = 1'b1;
        result.op.fload = 1'b1;
        result.lsu_op = LSU_FW;
        legal = (funct3 == 3'b010);
      end
      OPC_STORE_FP: begin
        result.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        result.op.rden1 = 1'b1;
        result.op.frden2 = 1'b1;
        result.op.fstore = 1'b1;
        result.lsu_op = LSU_FW;
        legal = (funct3 == 3'b010);
      end
      OPC_OP_FP: begin
        result.op.fwren = 1'b1;
        result.op.frden1 = 1'b1;
        result.op.frden2 = 1'b1;
        result.op.fpu = 1'b1;
        result.rm = funct3;
        result.fmt = instr[26:25];
        legal = rm_ok && (instr[26:25] == 2'b00);
        case (instr[31:27])
          5'b00000: result.fpu_op = FPU_ADD;
          5'b00001: result.fpu_op = FPU_SUB;
          5'b00010: result.fpu_op = FPU_MUL;
          5'b00011: result.fpu_op = FPU_DIV;
          default: legal = 1'b0;
        endcase
      end
      OPC_FMADD: begin
        result.op.fwren = 1'b1;
        result.op.frden1 = 1'b1;
        result.op.frden2 = 1'b1;
        result.op.frden3 = 1'b1; // rs3 in bits 31:27.
        result.op.fpu = 1'b1;
        result.fpu_op = FPU_MADD;
        result.rm = funct3;
        result.fmt = instr[26:25];
        legal = rm_ok && (instr[26:25] == 2'b00);
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    if (legal) begin
      result.op.valid = 1'b1;
    end else begin
      result = '0;
    end
  end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_stage
  import pipe_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  fetch_pkt_t  fetch,
  input  logic        halt,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  output logic [31:0] pc
);

  logic [31:0] pc_next;
  logic        advance;

  assign advance = fetch.ready & ~halt; // packet taken by decode.

  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (advance) begin
      pc_next = pc + 32'(`FETCH_BYTES);
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  fetch_pkt_t  fetch,
  input  logic [31:0] pc,
  input  logic        halt,
  input  logic        redirect,
  output logic [31:0] dec_instr0,
  output logic [31:0] dec_instr1,
  input  dec_result_t int_res0,
  input  dec_result_t int_res1,
  input  dec_result_t fp_res0,
  input  dec_result_t fp_res1,
  output slot_t       slot0,
  output slot_t       slot1
);

  slot_t slot0_next;
  slot_t slot1_next;
  logic  take;

  function automatic slot_t build_slot(logic [31:0] word, logic [31:0] addr,
                                       dec_result_t int_res, dec_result_t fp_res);
    slot_t s;
    s.pc = addr;
    s.npc = addr + 32'd4;
    s.instr = word;
    s.waddr = word[11:7];
    s.raddr1 = word[19:15];
    s.raddr2 = word[24:20];
    s.raddr3 = word[31:27];
    s.caddr = word[31:20];
    s.dec = fp_res.op.valid ? fp_res : int_res; // fp wins.
    if (!s.dec.op.valid) begin
      // neither decoder knows the word.
      s.dec.op.valid = 1'b1;
      s.dec.op.exception = 1'b1;
    end
    return s;
  endfunction

  assign dec_instr0 = fetch.rdata[31:0];
  assign dec_instr1 = fetch.rdata[63:32];

  assign take = fetch.ready & ~halt & ~redirect;

  always_comb begin
    if (take) begin
      slot0_next = build_slot(dec_instr0, pc, int_res0, fp_res0);
      slot1_next = build_slot(dec_instr1, pc + 32'd4, int_res1, fp_res1);
    end else begin
      slot0_next = '0; // bubble.
      slot1_next = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      slot0 <= '0;
      slot1 <= '0;
    end else begin
      slot0 <= slot0_next;
      slot1 <= slot1_next;
    end
  end

endmodule

// ==== hw/pair_stage.sv ====
`timescale 1ns/1ps

module pair_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  slot_t      slot0,
  input  slot_t      slot1,
  input  logic       redirect,
  output issue_pkt_t issue
);

  op_flags_t f0;
  op_flags_t f1;
  logic      ctrl0;
  logic      int_raw;
  logic      fp_raw;
  logic      mem_both;
  logic      pair_ok;

  assign f0 = slot0.dec.op;
  assign f1 = slot1.dec.op;

  // slot0 must not change the flow.
  assign ctrl0 = f0.exception | f0.branch | f0.jal | f0.jalr | f0.csreg |
                 f0.fence | f0.ecall | f0.ebreak | f0.mret | f0.wfi;

  assign int_raw = f0.wren && (slot0.waddr != '0) &&
                   ((f1.rden1 && slot1.raddr1 == slot0.waddr) ||
                    (f1.rden2 && slot1.raddr2 == slot0.waddr));

  assign fp_raw = f0.fwren &&
                  ((f1.frden1 && slot1.raddr1 == slot0.waddr) ||
                   (f1.frden2 && slot1.raddr2 == slot0.waddr) ||
                   (f1.frden3 && slot1.raddr3 == slot0.waddr));

  assign mem_both = (f0.load | f0.store | f0.fload | f0.fstore) &
                    (f1.load | f1.store | f1.fload | f1.fstore); // one memory port.

  assign pair_ok = f0.valid & f1.valid & ~ctrl0 & ~int_raw & ~fp_raw & ~mem_both;

  always_ff @(posedge clock) begin
    if (!reset || redirect) begin
      issue <= '0;
    end else begin
      issue.slot0 <= slot0;
      issue.slot1 <= slot1;
      issue.pair_ok <= pair_ok;
    end
  end

endmodule

// ==== hw/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  fetch_pkt_t  fetch,
  input  logic        halt,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  output logic [31:0] fetch_pc,
  output issue_pkt_t  issue
);

  logic [31:0] dec_instr0;
  logic [31:0] dec_instr1;
  dec_result_t int_res0;
  dec_result_t int_res1;
  dec_result_t fp_res0;
  dec_result_t fp_res1;
  slot_t       slot0;
  slot_t       slot1;

  fetch_stage u_fetch_stage (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .halt        (halt),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (fetch_pc)
  );

  decode_stage u_decode_stage (
    .clock      (clock),
    .reset      (reset),
    .fetch      (fetch),
    .pc         (fetch_pc),
    .halt       (halt),
    .redirect   (redirect),
    .dec_instr0 (dec_instr0),
    .dec_instr1 (dec_instr1),
    .int_res0   (int_res0),
    .int_res1   (int_res1),
    .fp_res0    (fp_res0),
    .fp_res1    (fp_res1),
    .slot0      (slot0),
    .slot1      (slot1)
  );

  int_decoder u_int_decoder0 (.instr(dec_instr0), .result(int_res0));
  int_decoder u_int_decoder1 (.instr(dec_instr1), .result(int_res1));
  fp_decoder u_fp_decoder0 (.instr(dec_instr0), .result(fp_res0));
  fp_decoder u_fp_decoder1 (.instr(dec_instr1), .result(fp_res1));

  pair_stage u_pair_stage (
    .clock    (clock),
    .reset    (reset),
    .slot0    (slot0),
    .slot1    (slot1),
    .redirect (redirect),
    .issue    (issue)
  );

endmodule

// ==== testbench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected decode of one word, illegal words already marked.
function automatic dec_result_t model_decode(logic [31:0] w);
  dec_result_t d;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [19:0] sx;
  logic        ok;
  d = '0;
  f3 = w[14:12];
  f7 = w[31:25];
  sx = {20{w[31]}};
  ok = 1'b1;
  case (w[6:0])
    OPC_LUI: begin
      d.imm = {w[31:12], 12'h000};
      d.op.wren = 1'b1;
      d.op.lui = 1'b1;
    end
    OPC_AUIPC: begin
      d.imm = {w[31:12], 12'h000};
      d.op.wren = 1'b1;
      d.op.auipc = 1'b1;
    end
    OPC_JAL: begin
      d.imm = {sx[11:0], w[19:12], w[20], w[30:21], 1'b0};
      d.op.wren = 1'b1;
      d.op.jal = 1'b1;
    end
    OPC_JALR: begin
      d.imm = {sx, w[31:20]};
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.jalr = 1'b1;
      ok = (f3 == 3'd0);
    end
    OPC_BRANCH: begin
      d.imm = {sx[18:0], w[31], w[7], w[30:25], w[11:8], 1'b0};
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
      d.op.branch = 1'b1;
      ok = (f3 != 3'd2) && (f3 != 3'd3);
    end
    OPC_LOAD: begin
      d.imm = {sx, w[31:20]};
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.load = 1'b1;
      case (f3)
        3'd0: d.lsu_op = LSU_LB;
        3'd1: d.lsu_op = LSU_LH;
        3'd2: d.lsu_op = LSU_LW;
        3'd4: d.lsu_op = LSU_LBU;
        3'd5: d.lsu_op = LSU_LHU;
        default: ok = 1'b0;
      endcase
    end
    OPC_STORE: begin
      d.imm = {sx, w[31:25], w[11:7]};
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
      d.op.store = 1'b1;
      case (f3)
        3'd0: d.lsu_op = LSU_SB;
        3'd1: d.lsu_op = LSU_SH;
        3'd2: d.lsu_op = LSU_SW;
        default: ok = 1'b0;
      endcase
    end
    OPC_OP_IMM: begin
      d.imm = {sx, w[31:20]};
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.alu = 1'b1;
      case (f3)
        3'd0: d.alu_op = ALU_ADD;
        3'd1: begin
          d.alu_op = ALU_SLL;
          ok = (f7 == 7'h00);
        end
        3'd2: d.alu_op = ALU_SLT;
        3'd3: d.alu_op = ALU_SLTU;
        3'd4: d.alu_op = ALU_XOR;
        3'd5: begin
          d.alu_op = w[30] ? ALU_SRA : ALU_SRL;
          ok = (f7 == 7'h00) || (f7 == 7'h20);
        end
        3'd6: d.alu_op = ALU_OR;
        default: d.alu_op = ALU_AND;
      endcase
    end
    OPC_OP: begin
      d.op.wren = 1'b1;
      d.op.rden1 = 1'b1;
      d.op.rden2 = 1'b1;
      if (f7 == 7'h01) begin
        d.op.mdu = 1'b1;
        case (f3)
          3'd0: d.mdu_op = MDU_MUL;
          3'd1: d.mdu_op = MDU_MULH;
          3'd2: d.mdu_op = MDU_MULHSU;
          3'd3: d.mdu_op = MDU_MULHU;
          3'd4: d.mdu_op = MDU_DIV;
          3'd5: d.mdu_op = MDU_DIVU;
          3'd6: d.mdu_op = MDU_REM;
          default: d.mdu_op = MDU_REMU;
        endcase
      end else begin
        d.op.alu = 1'b1;
        case ({f7, f3})
          {7'h00, 3'd0}: d.alu_op = ALU_ADD;
          {7'h20, 3'd0}: d.alu_op = ALU_SUB;
          {7'h00, 3'd1}: d.alu_op = ALU_SLL;
          {7'h00, 3'd2}: d.alu_op = ALU_SLT;
          {7'h00, 3'd3}: d.alu_op = ALU_SLTU;
          {7'h00, 3'd4}: d.alu_op = ALU_XOR;
          {7'h00, 3'd5}: d.alu_op = ALU_SRL;
          {7'h20, 3'd5}: d.alu_op = ALU_SRA;
          {7'h00, 3'd6}: d.alu_op = ALU_OR;
          {7'h00, 3'd7}: d.alu_op = ALU_AND;
          default: ok = 1'b0;
        endcase
      end
    end
    OPC_MISC_MEM: begin
      d.op.fence = 1'b1;
      ok = (f3 == 3'd0);
    end
    OPC_SYSTEM: begin
      if (f3 == 3'd0) begin
        case (w)
          32'h0000_0073: d.op.ecall = 1'b1;
          32'h0010_0073: d.op.ebreak = 1'b1;
          32'h3020_0073: d.op.mret = 1'b1;
          32'h1050_0073: d.op.wfi = 1'b1;
          default: ok = 1'b0;
        endcase
      end else begin
        d.imm = {27'd0, w[19:15]}; // zimm.
        d.op.wren = 1'b1;
        d.op.rden1 = (f3 < 3'd4);
        d.op.csreg = 1'b1;
        ok = (f3 != 3'd4);
      end
    end
    OPC_LOAD_FP: begin
      d.imm = {sx, w[31:20]};
      d.op.rden1 = 1'b1;
      d.op.fwren = 1'b1;
      d.op.fload = 1'b1;
      d.lsu_op = LSU_FW;
      ok = (f3 == 3'd2);
    end
    OPC_STORE_FP: begin
      d.imm = {sx, w[31:25], w[11:7]};
      d.op.rden1 = 1'b1;
      d.op.frden2 = 1'b1;
      d.op.fstore = 1'b1;
      d.lsu_op = LSU_FW;
      ok = (f3 == 3'd2);
    end
    OPC_OP_FP, OPC_FMADD: begin
      d.op.fwren = 1'b1;
      d.op.frden1 = 1'b1;
      d.op.frden2 = 1'b1;
      d.op.fpu = 1'b1;
      d.rm = f3;
      d.fmt = w[26:25];
      ok = (w[26:25] == 2'b00) && (f3 != 3'd5) && (f3 != 3'd6);
      if (w[6:0] == OPC_FMADD) begin
        d.op.frden3 = 1'b1;
        d.fpu_op = FPU_MADD;
      end else begin
        case (w[31:27])
          5'd0: d.fpu_op = FPU_ADD;
          5'd1: d.fpu_op = FPU_SUB;
          5'd2: d.fpu_op = FPU_MUL;
          5'd3: d.fpu_op = FPU_DIV;
          default: ok = 1'b0;
        endcase
      end
    end
    default: ok = 1'b0;
  endcase
  if (ok) begin
    d.op.valid = 1'b1;
  end else begin
    d = '0;
    d.op.valid = 1'b1;
    d.op.exception = 1'b1;
  end
  return d;
endfunction

function automatic slot_t model_slot(logic [31:0] w, logic [31:0] addr);
  slot_t s;
  s.pc = addr;
  s.npc = addr + 32'd4;
  s.instr = w;
  s.waddr = w[11:7];
  s.raddr1 = w[19:15];
  s.raddr2 = w[24:20];
  s.raddr3 = w[31:27];
  s.caddr = w[31:20];
  s.dec = model_decode(w);
  return s;
endfunction

// dual issue allowed for this pair.
function automatic logic model_pair(slot_t s0, slot_t s1);
  op_flags_t a;
  op_flags_t b;
  logic      ok;
  a = s0.dec.op;
  b = s1.dec.op;
  ok = a.valid && b.valid;
  if (a.exception || a.branch || a.jal || a.jalr || a.csreg) begin
    ok = 1'b0;
  end
  if (a.fence || a.ecall || a.ebreak || a.mret || a.wfi) begin
    ok = 1'b0;
  end
  if (a.wren && s0.waddr != 5'd0) begin
    if ((b.rden1 && s1.raddr1 == s0.waddr) || (b.rden2 && s1.raddr2 == s0.waddr)) begin
      ok = 1'b0;
    end
  end
  if (a.fwren) begin
    if ((b.frden1 && s1.raddr1 == s0.waddr) || (b.frden2 && s1.raddr2 == s0.waddr) ||
        (b.frden3 && s1.raddr3 == s0.waddr)) begin
      ok = 1'b0;
    end
  end
  if ((a.load || a.store || a.fload || a.fstore) &&
      (b.load || b.store || b.fload || b.fstore)) begin
    ok = 1'b0;
  end
  return ok;
endfunction

`endif

// ==== testbench/tb_frontend_top.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_frontend_top
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int NUM_CYCLES = 3000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 200; // reset and pipeline drain.

  logic        clock;
  logic        reset;
  fetch_pkt_t  fetch;
  logic        halt;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] fetch_pc;
  issue_pkt_t  issue;

  integer      seed;
  int          cycle_count = 0;
  int          error_count = 0;
  int          pair_count = 0;
  int          exc_count = 0;
  logic [31:0] model_pc;
  issue_pkt_t  exp_q[$]; // decode register, then the packet entering it.

  `include "decode_model.svh"

  frontend_top u_frontend_top (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .halt        (halt),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_pc    (fetch_pc),
    .issue       (issue)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  task automatic report_failure(string msg);
    error_count++;
    $display("Fail at %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "mismatch");
  endtask

  task automatic check_slot(string name, slot_t got, slot_t exp);
    assert (got === exp)
    else report_failure($sformatf("%s word %h pc %h: got pc %h dec %h, expected pc %h dec %h",
                                  name, exp.instr, exp.pc, got.pc, got.dec, exp.pc, exp.dec));
  endtask

  // legal template with random fields, or a raw word now and then.
  task automatic make_word(output logic [31:0] w);
    logic [31:0] r;
    int          pick;
    r = $random(seed);
    pick = {$random(seed)} % 20;
    if ($random(seed) & 1) begin
      r = r & ~32'h00C6_0600; // low registers, more hazards.
    end
    case (pick)
      0: w = {r[31:7], OPC_LUI};
      1: w = {r[31:7], OPC_AUIPC};
      2: w = {r[31:7], OPC_JAL};
      3: w = {r[31:15], 3'b000, r[11:7], OPC_JALR};
      4: w = {r[31:7], OPC_BRANCH};
      5: w = {r[31:7], OPC_LOAD};
      6: w = {r[31:15], 1'b0, r[13:7], OPC_STORE};
      7: w = {r[31:7], OPC_OP_IMM};
      8: w = {1'b0, r[30], 5'b00000, r[24:7], OPC_OP_IMM};
      9: w = {1'b0, r[30], 5'b00000, r[24:7], OPC_OP};
      10: w = {7'b0000001, r[24:7], OPC_OP};
      11: w = {r[31:15], 3'b000, r[11:7], OPC_MISC_MEM};
      12: begin
        case (r[1:0])
          2'd0: w = 32'h0000_0073;
          2'd1: w = 32'h0010_0073;
          2'd2: w = 32'h3020_0073;
          default: w = 32'h1050_0073;
        endcase
      end
      13: w = {r[31:7], OPC_SYSTEM};
      14: w = {r[31:15], 3'b010, r[11:7], OPC_LOAD_FP};
      15: w = {r[31:15], 3'b010, r[11:7], OPC_STORE_FP};
      16: w = {3'b000, r[28:27], 2'b00, r[24:7], OPC_OP_FP};
      17: w = {r[31:27], 2'b00, r[24:7], OPC_FMADD};
      default: w = r;
    endcase
  endtask

  // drive one cycle of inputs and advance the model to the next edge.
  task automatic drive_cycle();
    logic [31:0] w0;
    logic [31:0] w1;
    issue_pkt_t  entry;
    make_word(w0);
    make_word(w1);
    fetch.ready = ({$random(seed)} % 4) != 0;
    fetch.rdata = {w1, w0}; // the two words at fetch_pc.
    halt = ({$random(seed)} % 100) < 5;
    redirect = ({$random(seed)} % 100) < 3;
    redirect_pc = $random(seed) & ~32'h7;
    entry = '0;
    if (fetch.ready && !halt && !redirect) begin
      entry.slot0 = model_slot(w0, model_pc);
      entry.slot1 = model_slot(w1, model_pc + 32'd4);
      entry.pair_ok = model_pair(entry.slot0, entry.slot1);
    end
    if (redirect) begin
      foreach (exp_q[i]) begin
        exp_q[i] = '0;
      end
    end
    exp_q.push_back(entry);
    if (redirect) begin
      model_pc = redirect_pc;
    end else if (fetch.ready && !halt) begin
      model_pc = model_pc + 32'd8;
    end
  endtask

  task automatic check_outputs();
    issue_pkt_t exp;
    exp = exp_q.pop_front();
    assert (fetch_pc === model_pc)
    else report_failure($sformatf("fetch_pc %h, expected %h", fetch_pc, model_pc));
    check_slot("slot0", issue.slot0, exp.slot0);
    check_slot("slot1", issue.slot1, exp.slot1);
    assert (issue.pair_ok === exp.pair_ok)
    else report_failure($sformatf("pair_ok %b, expected %b for words %h %h",
                                  issue.pair_ok, exp.pair_ok, exp.slot0.instr, exp.slot1.instr));
    if (exp.pair_ok) begin
      pair_count++;
    end
    if (exp.slot0.dec.op.exception || exp.slot1.dec.op.exception) begin
      exc_count++;
    end
  endtask

  initial begin
    issue_pkt_t bubble;
    seed = 87687;
    bubble = '0;
    reset = 1'b0;
    fetch.ready = 1'b1; // packets offered while reset is held.
    fetch.rdata = {$random(seed), $random(seed)};
    halt = 1'b0;
    redirect = 1'b0;
    redirect_pc = 32'd0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b1;
    assert (fetch_pc === `RESET_PC)
    else report_failure($sformatf("fetch_pc %h after reset", fetch_pc));
    assert (issue === bubble)
    else report_failure("issue output is not a bubble after reset");
    model_pc = `RESET_PC;
    exp_q.delete();
    exp_q.push_back(bubble);
    for (int i = 0; i < NUM_CYCLES; i++) begin
      drive_cycle();
      @(posedge clock);
      #1;
      check_outputs();
    end
    $display("%0d cycles, %0d pairs issued, %0d with exceptions",
             NUM_CYCLES, pair_count, exc_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "checks failed");
    end
  end

endmodule

// ==== filelist.f ====
+incdir+hw
+incdir+testbench
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/int_decoder.sv
hw/fp_decoder.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/pair_stage.sv
hw/frontend_top.sv
testbench/tb_frontend_top.sv
